// File: src/mips_macros.svh
/*
 * shared constants of the three-stage MIPS integer pipeline
 * widths, instruction field ranges, opcodes and funct codes
 * include this wherever a width or an instruction code is needed
 */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath width and register file depth
`define MIPS_XLEN 32
`define MIPS_NREGS 32

// instruction field ranges, used as inst[`MIPS_F_xx]
`define MIPS_F_OP 31:26
`define MIPS_F_RS 25:21
`define MIPS_F_RT 20:16
`define MIPS_F_RD 15:11
`define MIPS_F_SHAMT 10:6
`define MIPS_F_FUNCT 5:0
`define MIPS_F_IMM 15:0

// primary opcodes
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_SLTI 6'h0a
`define MIPS_OP_SLTIU 6'h0b
`define MIPS_OP_ANDI 6'h0c
`define MIPS_OP_ORI 6'h0d
`define MIPS_OP_XORI 6'h0e
`define MIPS_OP_LUI 6'h0f

// funct codes of the supported R-type operations
`define MIPS_FN_SLL 6'h00
`define MIPS_FN_SRL 6'h02
`define MIPS_FN_SRA 6'h03
`define MIPS_FN_SLLV 6'h04
`define MIPS_FN_SRLV 6'h06
`define MIPS_FN_SRAV 6'h07
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND 6'h24
`define MIPS_FN_OR 6'h25
`define MIPS_FN_XOR 6'h26
`define MIPS_FN_NOR 6'h27
`define MIPS_FN_SLT 6'h2a
`define MIPS_FN_SLTU 6'h2b

// width of the hazard stall countdown
`define MIPS_STALL_BITS 2

`endif

// File: src/mips_pkg.sv
/*
 * types shared by the pipeline stages and the testbench
 * import with mips_pkg::* in the module header
 */
`include "mips_macros.svh"

package mips_pkg;

   // one data word
   typedef logic [`MIPS_XLEN-1:0] word_t;

   // register number, 5 bits for 32 registers
   typedef logic [$clog2(`MIPS_NREGS)-1:0] reg_idx_t;

   // alu operations, pass_b carries the LUI operand straight through
   typedef enum logic [3:0] {
      ALU_ADDU, ALU_SUBU, ALU_AND, ALU_OR,
      ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV,
      ALU_SRLV, ALU_SRAV, ALU_PASS_B
   } alu_op_t;

endpackage

// File: src/mips_regfile.sv
/*
 * integer register file, two combinational reads and one write
 * register 0 reads zero and ignores writes
 * a read of the register written this cycle returns the new value
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_regfile import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t rs_idx,
   input  reg_idx_t rt_idx,
   output word_t    rs_data,
   output word_t    rt_data,
   input  logic     wr_en,
   input  reg_idx_t wr_reg,
   input  word_t    wr_data
);

   // r1..r31, r0 has no storage
   word_t regs [1:`MIPS_NREGS-1];

   // zero register, then write-through, then stored value
   function automatic word_t read_port(reg_idx_t idx);
      if (idx == '0) return '0;
      if (wr_en && idx == wr_reg) return wr_data;
      return regs[idx];
   endfunction

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < `MIPS_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_reg != '0) begin
         regs[wr_reg] <= wr_data;
      end
   end

   // reads follow the stored registers and the write port
   always_comb begin
      rs_data = read_port(rs_idx);
      rt_data = read_port(rt_idx);
   end

endmodule

// File: src/mips_hazard.sv
/*
 * RAW hazard check for the instruction offered on inst
 * compares its sources against the writers held in decode and execute
 * and holds inst_ready low until the producer reaches writeback
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_hazard import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t src_rs,
   input  reg_idx_t src_rt,
   input  reg_idx_t dec_dst,
   input  logic     dec_wr,
   input  reg_idx_t exe_dst,
   input  logic     exe_wr,
   input  logic     inst_valid,
   output logic     inst_ready
);

   logic                        dec_hit;
   logic                        exe_hit;
   logic                        hit;
   logic [`MIPS_STALL_BITS-1:0] stall_len;
   logic [`MIPS_STALL_BITS-1:0] stall_cnt;

   // a nonzero source that a pending write will change
   function automatic logic depends(reg_idx_t dst, logic wr);
      return wr && dst != '0 && (src_rs == dst || src_rt == dst);
   endfunction

   always_comb begin
      dec_hit = depends(dec_dst, dec_wr);
      exe_hit = depends(exe_dst, exe_wr);
   end

   assign hit = inst_valid && (dec_hit || exe_hit);

   // producer in decode needs two more edges, in execute one
   assign stall_len = dec_hit ? `MIPS_STALL_BITS'd2 : `MIPS_STALL_BITS'd1;

   assign inst_ready = !hit && stall_cnt == '0;

   // the detecting cycle is already the first stall cycle
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         stall_cnt <= '0;
      end else if (hit && stall_cnt == '0) begin
         stall_cnt <= stall_len - 1'b1;
      end else if (stall_cnt != '0) begin
         stall_cnt <= stall_cnt - 1'b1;
      end
   end

endmodule

// File: src/mips_decode.sv
/*
 * decode stage: splits the offered instruction into its fields,
 * reads the register file and picks the alu operation and operands
 * the decode/execute register loads on accept, a bubble otherwise
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_decode import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  word_t    inst,
   input  logic     accept,
   output reg_idx_t rs_idx,
   output reg_idx_t rt_idx,
   input  word_t    rs_data,
   input  word_t    rt_data,
   output reg_idx_t dec_dst,
   output logic     dec_wr,
   output alu_op_t  dec_op,
   output word_t    dec_a,
   output word_t    dec_b
);

   logic [5:0]  opcode;
   logic [5:0]  funct;
   reg_idx_t    rd_idx;
   logic [4:0]  shamt;
   logic [15:0] imm;
   word_t       imm_se;
   word_t       imm_ze;
   word_t       imm_up;
   logic        is_rtype;
   logic        shift_imm;
   logic        supported;
   alu_op_t     op;
   word_t       opnd_a;
   word_t       opnd_b;
   reg_idx_t    dst;

   // field split
   assign opcode = inst[`MIPS_F_OP];
   assign rs_idx = inst[`MIPS_F_RS];
   assign rt_idx = inst[`MIPS_F_RT];
   assign rd_idx = inst[`MIPS_F_RD];
   assign shamt  = inst[`MIPS_F_SHAMT];
   assign funct  = inst[`MIPS_F_FUNCT];
   assign imm    = inst[`MIPS_F_IMM];

   // immediate forms
   assign imm_se = {{(`MIPS_XLEN-16){imm[15]}}, imm};
   assign imm_ze = {{(`MIPS_XLEN-16){1'b0}}, imm};
   assign imm_up = {imm, 16'h0000};

   assign is_rtype = opcode == `MIPS_OP_RTYPE;
   // sll, srl and sra take the amount from shamt
   assign shift_imm = is_rtype && (funct == `MIPS_FN_SLL || funct == `MIPS_FN_SRL ||
                                   funct == `MIPS_FN_SRA);

   // operation, unknown codes fall through as unsupported
   always_comb begin
      op = ALU_ADDU;
      supported = 1'b1;
      case (opcode)
         `MIPS_OP_RTYPE: begin
            case (funct)
               `MIPS_FN_SLL:  op = ALU_SLL;
               `MIPS_FN_SRL:  op = ALU_SRL;
               `MIPS_FN_SRA:  op = ALU_SRA;
               `MIPS_FN_SLLV: op = ALU_SLLV;
               `MIPS_FN_SRLV: op = ALU_SRLV;
               `MIPS_FN_SRAV: op = ALU_SRAV;
               `MIPS_FN_ADDU: op = ALU_ADDU;
               `MIPS_FN_SUBU: op = ALU_SUBU;
               `MIPS_FN_AND:  op = ALU_AND;
               `MIPS_FN_OR:   op = ALU_OR;
               `MIPS_FN_XOR:  op = ALU_XOR;
               `MIPS_FN_NOR:  op = ALU_NOR;
               `MIPS_FN_SLT:  op = ALU_SLT;
               `MIPS_FN_SLTU: op = ALU_SLTU;
               default:       supported = 1'b0;
            endcase
         end
         `MIPS_OP_ADDIU: op = ALU_ADDU;
         `MIPS_OP_SLTI:  op = ALU_SLT;
         `MIPS_OP_SLTIU: op = ALU_SLTU;
         `MIPS_OP_ANDI:  op = ALU_AND;
         `MIPS_OP_ORI:   op = ALU_OR;
         `MIPS_OP_XORI:  op = ALU_XOR;
         `MIPS_OP_LUI:   op = ALU_PASS_B;
         default:        supported = 1'b0;
      endcase
   end

   // second operand, sltiu still compares against the sign-extended value
   always_comb begin
      case (opcode)
         `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU: opnd_b = imm_se;
         `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI:    opnd_b = imm_ze;
         `MIPS_OP_LUI:                                  opnd_b = imm_up;
         default:                                       opnd_b = rt_data;
      endcase
   end

   assign opnd_a = shift_imm ? word_t'(shamt) : rs_data;
   assign dst    = is_rtype ? rd_idx : rt_idx;

   // high only for an accepted, supported write to a nonzero register
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         dec_wr <= 1'b0;
      end else begin
         dec_wr <= accept && supported && dst != '0;
      end
   end

   // payload loads every cycle, ignored while dec_wr is low
   always_ff @(posedge clk) begin
      dec_dst <= dst;
      dec_op  <= op;
      dec_a   <= opnd_a;
      dec_b   <= opnd_b;
   end

endmodule

// File: src/mips_execute.sv
/*
 * execute stage: the alu and the execute/result register
 * shift amounts arrive in the low 5 bits of the first operand,
 * shamt for fixed shifts and rs for variable ones
 */
`timescale 1ns/1ps

module mips_execute import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  alu_op_t  dec_op,
   input  word_t    dec_a,
   input  word_t    dec_b,
   input  reg_idx_t dec_dst,
   input  logic     dec_wr,
   output reg_idx_t exe_dst,
   output logic     exe_wr,
   output word_t    exe_result
);

   word_t      alu_out;
   logic [4:0] sh_amt;

   // only the low 5 bits count, amounts above 31 wrap
   assign sh_amt = dec_a[4:0];

   always_comb begin
      case (dec_op)
         ALU_ADDU: alu_out = dec_a + dec_b;
         ALU_SUBU: alu_out = dec_a - dec_b;
         ALU_AND:  alu_out = dec_a & dec_b;
         ALU_OR:   alu_out = dec_a | dec_b;
         ALU_XOR:  alu_out = dec_a ^ dec_b;
         ALU_NOR:  alu_out = ~(dec_a | dec_b);
         // signed and unsigned set-less-than
         ALU_SLT:  alu_out = word_t'($signed(dec_a) < $signed(dec_b));
         ALU_SLTU: alu_out = word_t'(dec_a < dec_b);
         // the shifted value is always rt
         ALU_SLL, ALU_SLLV: alu_out = dec_b << sh_amt;
         ALU_SRL, ALU_SRLV: alu_out = dec_b >> sh_amt;
         // arithmetic shift copies the sign bit in
         ALU_SRA, ALU_SRAV: alu_out = word_t'($signed(dec_b) >>> sh_amt);
         ALU_PASS_B: alu_out = dec_b;
         default:  alu_out = dec_b;
      endcase
   end

   // write flag follows the decode flag every cycle
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         exe_wr <= 1'b0;
      end else begin
         exe_wr <= dec_wr;
      end
   end

   always_ff @(posedge clk) begin
      exe_dst    <= dec_dst;
      exe_result <= alu_out;
   end

endmodule

// File: src/mips_result.sv
/*
 * writeback register at the end of the pipeline
 * its outputs are both the retire port and the register file write,
 * so a retire and the matching register write happen in the same cycle
 */
`timescale 1ns/1ps

module mips_result import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t exe_dst,
   input  logic     exe_wr,
   input  word_t    exe_result,
   output logic     retire_valid,
   output reg_idx_t retire_reg,
   output word_t    retire_data
);

   // bubbles and r0 writes arrive with exe_wr low and never retire
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         retire_valid <= 1'b0;
      end else begin
         retire_valid <= exe_wr;
      end
   end

   // register number and data only matter with retire_valid high
   always_ff @(posedge clk) begin
      retire_reg  <= exe_dst;
      retire_data <= exe_result;
   end

endmodule

// File: src/mips_core.sv
/*
 * top level of the three-stage MIPS integer pipeline
 * instructions enter on inst with a valid/ready handshake and every
 * register write is reported on the retire port three cycles later
 */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  word_t    inst,
   input  logic     inst_valid,
   output logic     inst_ready,
   output logic     retire_valid,
   output reg_idx_t retire_reg,
   output word_t    retire_data
);

   logic     accept;
   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   word_t    rs_data;
   word_t    rt_data;
   reg_idx_t dec_dst;
   logic     dec_wr;
   alu_op_t  dec_op;
   word_t    dec_a;
   word_t    dec_b;
   reg_idx_t exe_dst;
   logic     exe_wr;
   word_t    exe_result;

   // handshake completes on this edge
   assign accept = inst_valid && inst_ready;

   // write port shares the retire nets
   mips_regfile u_regfile (
      .clk, .rst_b, .rs_idx, .rt_idx, .rs_data, .rt_data,
      .wr_en(retire_valid), .wr_reg(retire_reg), .wr_data(retire_data)
   );

   mips_hazard u_hazard (
      .clk, .rst_b, .src_rs(rs_idx), .src_rt(rt_idx),
      .dec_dst, .dec_wr, .exe_dst, .exe_wr, .inst_valid, .inst_ready
   );

   mips_decode u_decode (
      .clk, .rst_b, .inst, .accept, .rs_idx, .rt_idx, .rs_data, .rt_data,
      .dec_dst, .dec_wr, .dec_op, .dec_a, .dec_b
   );

   mips_execute u_execute (
      .clk, .rst_b, .dec_op, .dec_a, .dec_b, .dec_dst, .dec_wr,
      .exe_dst, .exe_wr, .exe_result
   );

   mips_result u_result (
      .clk, .rst_b, .exe_dst, .exe_wr, .exe_result,
      .retire_valid, .retire_reg, .retire_data
   );

endmodule

// File: tests/mips_core_tb.sv
/*
 * testbench for the three-stage MIPS integer pipeline
 * builds a program of directed and random instructions, offers them on
 * the valid/ready port and checks every retire against a shadow model
 * run with the file list in the project root, top module mips_core_tb
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core_tb import mips_pkg::*; ();

   localparam logic [5:0] functs [14] = '{
      `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA, `MIPS_FN_SLLV, `MIPS_FN_SRLV,
      `MIPS_FN_SRAV, `MIPS_FN_ADDU, `MIPS_FN_SUBU, `MIPS_FN_AND, `MIPS_FN_OR,
      `MIPS_FN_XOR, `MIPS_FN_NOR, `MIPS_FN_SLT, `MIPS_FN_SLTU
   };
   localparam logic [5:0] imm_ops [7] = '{
      `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU, `MIPS_OP_ANDI,
      `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI
   };

   logic     clk;
   logic     rst_b;
   word_t    inst;
   logic     inst_valid;
   logic     inst_ready;
   logic     retire_valid;
   reg_idx_t retire_reg;
   word_t    retire_data;

   integer   seed = 32'h2845_2657;
   word_t    shadow [0:`MIPS_NREGS-1];
   word_t    prog [$];
   reg_idx_t exp_reg [$];
   word_t    exp_data [$];
   int       cycles = 0;
   int       limit;
   logic     stalled;

   mips_core u_mips_core (
      .clk, .rst_b, .inst, .inst_valid, .inst_ready,
      .retire_valid, .retire_reg, .retire_data
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic word_t r_op(logic [5:0] fn, int rd, int rs, int rt, int sh);
      return {`MIPS_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
   endfunction

   function automatic word_t i_op(logic [5:0] op, int rt, int rs, logic [15:0] imm);
      return {op, rs[4:0], rt[4:0], imm};
   endfunction

   // ISA result of w on the shadow registers, with its destination
   function automatic word_t expected_value(input word_t w, output reg_idx_t dst,
                                            output logic wr);
      word_t a;
      word_t b;
      word_t sx;
      word_t zx;
      word_t v;
      logic  ok;
      a   = shadow[w[25:21]];
      b   = shadow[w[20:16]];
      sx  = {{16{w[15]}}, w[15:0]};
      zx  = {16'h0000, w[15:0]};
      v   = '0;
      ok  = 1'b1;
      dst = (w[31:26] == `MIPS_OP_RTYPE) ? w[15:11] : w[20:16];
      case (w[31:26])
         `MIPS_OP_RTYPE: begin
            case (w[5:0])
               `MIPS_FN_SLL:  v = b << w[10:6];
               `MIPS_FN_SRL:  v = b >> w[10:6];
               `MIPS_FN_SRA:  v = $signed(b) >>> w[10:6];
               `MIPS_FN_SLLV: v = b << a[4:0];
               `MIPS_FN_SRLV: v = b >> a[4:0];
               `MIPS_FN_SRAV: v = $signed(b) >>> a[4:0];
               `MIPS_FN_ADDU: v = a + b;
               `MIPS_FN_SUBU: v = a - b;
               `MIPS_FN_AND:  v = a & b;
               `MIPS_FN_OR:   v = a | b;
               `MIPS_FN_XOR:  v = a ^ b;
               `MIPS_FN_NOR:  v = ~(a | b);
               `MIPS_FN_SLT:  v = {31'd0, $signed(a) < $signed(b)};
               `MIPS_FN_SLTU: v = {31'd0, a < b};
               default:       ok = 1'b0;
            endcase
         end
         `MIPS_OP_ADDIU: v = a + sx;
         `MIPS_OP_SLTI:  v = {31'd0, $signed(a) < $signed(sx)};
         `MIPS_OP_SLTIU: v = {31'd0, a < sx};
         `MIPS_OP_ANDI:  v = a & zx;
         `MIPS_OP_ORI:   v = a | zx;
         `MIPS_OP_XORI:  v = a ^ zx;
         `MIPS_OP_LUI:   v = {w[15:0], 16'h0000};
         default:        ok = 1'b0;
      endcase
      wr = ok && dst != '0;
      return v;
   endfunction

   // random kept instruction on r0..r7 so that dependences are frequent
   function automatic word_t rand_inst();
      int    k;
      word_t bits;
      k    = $unsigned($random(seed)) % 21;
      bits = $random(seed);
      if (k < 14) return r_op(functs[k], bits[24:22], bits[18:16], bits[21:19], bits[29:25]);
      return i_op(imm_ops[k-14], bits[21:19], bits[18:16], bits[15:0]);
   endfunction

   task automatic stop_run(string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "run stopped on the first error");
   endtask

   // offer w until accepted, then record its expected write
   task automatic send_inst(word_t w);
      reg_idx_t dst;
      logic     wr;
      logic     taken;
      word_t    v;
      inst       = w;
      inst_valid = 1'b1;
      taken      = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = inst_ready;
         if (!inst_ready) stalled = 1'b1;
         @(posedge clk);
         #1;
      end
      inst_valid = 1'b0;
      v = expected_value(w, dst, wr);
      if (wr) begin
         exp_reg.push_back(dst);
         exp_data.push_back(v);
         shadow[dst] = v;
      end
   endtask

   // each retire must match the oldest outstanding write
   always @(negedge clk) begin
      if (rst_b && retire_valid) begin
         assert (exp_reg.size() != 0)
         else stop_run($sformatf("retire of r%0d at %0t when no write was due", retire_reg, $time));
         assert (retire_reg == exp_reg[0])
         else stop_run($sformatf("Fail at %0t: retire_reg is %0d, expected %0d",
                                 $time, retire_reg, exp_reg[0]));
         assert (retire_data == exp_data[0])
         else stop_run($sformatf("Fail at %0t: retire_data is %h, expected %h",
                                 $time, retire_data, exp_data[0]));
         exp_reg.delete(0);
         exp_data.delete(0);
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit) stop_run($sformatf("timeout, run still busy after %0d cycles", limit));
   end

   initial begin
      int n_directed;
      int gap;
      int dep_first;
      int dep_last;
      rst_b      = 1'b0;
      inst       = '0;
      inst_valid = 1'b0;
      stalled    = 1'b0;
      foreach (shadow[i]) shadow[i] = '0;
      // r1 negative, r2 large positive, r3 minus two, r4 five
      prog.push_back(i_op(`MIPS_OP_LUI, 1, 0, 16'h8000));
      prog.push_back(i_op(`MIPS_OP_ORI, 1, 1, 16'h0001));
      prog.push_back(i_op(`MIPS_OP_LUI, 2, 0, 16'h7fff));
      prog.push_back(i_op(`MIPS_OP_ORI, 2, 2, 16'hfff0));
      prog.push_back(i_op(`MIPS_OP_LUI, 3, 0, 16'hffff));
      prog.push_back(i_op(`MIPS_OP_ORI, 3, 3, 16'hfffe));
      prog.push_back(i_op(`MIPS_OP_ORI, 4, 0, 16'h0005));
      // arithmetic, logic and compares on two operand pairs
      for (int k = 6; k < 14; k++) begin
         prog.push_back(r_op(functs[k], k + 4, 1, 2, 0));
         prog.push_back(r_op(functs[k], k + 12, 3, 4, 0));
      end
      // immediates with bit 15 set
      for (int k = 0; k < 7; k++) begin
         prog.push_back(i_op(imm_ops[k], k + 10, 4, 16'hfff0));
         prog.push_back(i_op(imm_ops[k], k + 20, 3, 16'h8001));
      end
      // fixed shifts at several amounts, variable ones by 33 and 63
      prog.push_back(i_op(`MIPS_OP_ORI, 28, 0, 16'd33));
      prog.push_back(i_op(`MIPS_OP_ORI, 29, 0, 16'd63));
      for (int k = 0; k < 3; k++) begin
         for (int s = 1; s < 32; s = s * 2 + 1) prog.push_back(r_op(functs[k], 5, 0, 1, s));
         prog.push_back(r_op(functs[k + 3], 6, 28, 1, 0));
         prog.push_back(r_op(functs[k + 3], 7, 29, 1, 0));
      end
      // back-to-back and one-apart dependences
      dep_first = prog.size();
      prog.push_back(r_op(`MIPS_FN_ADDU, 5, 4, 4, 0));
      prog.push_back(r_op(`MIPS_FN_ADDU, 6, 5, 4, 0));
      prog.push_back(r_op(`MIPS_FN_SUBU, 7, 6, 1, 0));
      prog.push_back(r_op(`MIPS_FN_XOR, 8, 6, 7, 0));
      dep_last = prog.size() - 1;
      // r0 writes and unknown codes never retire, r0 and r9 keep their values
      prog.push_back(r_op(`MIPS_FN_ADDU, 0, 1, 2, 0));
      prog.push_back(i_op(`MIPS_OP_ORI, 0, 3, 16'h1234));
      prog.push_back(i_op(6'h3f, 9, 1, 16'h0001));
      prog.push_back(r_op(6'h3e, 9, 1, 2, 0));
      prog.push_back(r_op(`MIPS_FN_OR, 12, 0, 9, 0));
      n_directed = prog.size();
      repeat (200) prog.push_back(rand_inst());
      // at most three cycles between acceptances, plus reset and drain
      limit = 3 * prog.size() + 20;
      repeat (4) @(posedge clk);
      #1;
      rst_b = 1'b1;
      foreach (prog[i]) begin
         // stalls are only counted over the dependent sequence
         if (i == dep_first) stalled = 1'b0;
         send_inst(prog[i]);
         if (i == dep_last) begin
            assert (stalled)
            else stop_run("inst_ready never went low on dependent instructions");
         end
         if (i >= n_directed) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
               @(posedge clk);
               #1;
            end
         end
      end
      // last write retires two edges after its acceptance
      repeat (3) @(posedge clk);
      #1;
      assert (exp_reg.size() == 0)
      else stop_run($sformatf("%0d expected writes never retired", exp_reg.size()));
      $display("All tests passed");
      $finish;
   end

endmodule

// File: sim.f
+incdir+src
src/mips_pkg.sv
src/mips_regfile.sv
src/mips_hazard.sv
src/mips_decode.sv
src/mips_execute.sv
src/mips_result.sv
src/mips_core.sv
tests/mips_core_tb.sv

// File: Makefile
# Verilator build and run of the MIPS pipeline testbench

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module mips_core_tb -o mips_core_tb

run: compile
	./obj_dir/mips_core_tb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
